//--- verilog/lcd_defines.svh
`ifndef LCD_DEFINES_SVH
`define LCD_DEFINES_SVH

`define LCD_FRAME_W       64          // Widest frame, MSB-aligned
`define LCD_TOUCH_W       40          // Touch reply bits
`define LCD_LEN_CMD       7'd24
`define LCD_LEN_WRITE     7'd32
`define LCD_LEN_READ      7'd64

`define LCD_SCLK_HALF     2           // clk20MHz cycles per sclk half
`define LCD_CS_GAP        8           // Min cs_n high cycles between frames

`define LCD_FREQ_TILES    11
`define LCD_POLL_FRAMES   2           // Touch reads at the end of a pass
`define LCD_PASS_FRAMES   15

`define LCD_CMD_ACTIVE    24'h000000
`define LCD_CMD_TOUCH_RD  64'h3021240000000000
`define LCD_TOUCH_OK      8'h42       // Status byte of a valid reply

`define LCD_WR_CMD        8'hB0       // Memory write prefix
`define LCD_WR_PAGE       8'h00
`define LCD_TILE_BASE     8'h08
`define LCD_TILE_STEP     8'h10
`define LCD_COLOR_SEL     8'h00       // Selected tile
`define LCD_COLOR_IDLE    8'hFF

`define LCD_MODE_ADDR0    8'hB0
`define LCD_MODE_ADDR1    8'h01
`define LCD_MODE_ADDR2    8'h00

`define LCD_RUN_X_LO      16'd84
`define LCD_RUN_X_HI      16'd210
`define LCD_RUN_Y_LO      16'd768
`define LCD_RUN_Y_HI      16'd871
`define LCD_OFF_X_LO      16'd75
`define LCD_OFF_X_HI      16'd210
`define LCD_OFF_Y_LO      16'd545
`define LCD_OFF_Y_HI      16'd643
`define LCD_SWEEP_X_LO    16'd75
`define LCD_SWEEP_X_HI    16'd210
`define LCD_SWEEP_Y_LO    16'd312
`define LCD_SWEEP_Y_HI    16'd415
`define LCD_LOCK_X_LO     16'd75
`define LCD_LOCK_X_HI     16'd210
`define LCD_LOCK_Y_LO     16'd84
`define LCD_LOCK_Y_HI     16'd187

// Frequency tile columns, left to right
`define LCD_T1_X_LO       16'd311
`define LCD_T1_X_HI       16'd348
`define LCD_T2_X_LO       16'd372
`define LCD_T2_X_HI       16'd412
`define LCD_T3_X_LO       16'd432
`define LCD_T3_X_HI       16'd468
`define LCD_T4_X_LO       16'd492
`define LCD_T4_X_HI       16'd523
`define LCD_T5_X_LO       16'd553
`define LCD_T5_X_HI       16'd587
`define LCD_T6_X_LO       16'd616
`define LCD_T6_X_HI       16'd652
`define LCD_T7_X_LO       16'd670
`define LCD_T7_X_HI       16'd707
`define LCD_T8_X_LO       16'd736
`define LCD_T8_X_HI       16'd768
`define LCD_T9_X_LO       16'd791
`define LCD_T9_X_HI       16'd816
`define LCD_T10_X_LO      16'd848
`define LCD_T10_X_HI      16'd880
`define LCD_T11_X_LO      16'd909
`define LCD_T11_X_HI      16'd940
`define LCD_TILE_Y_HI     16'd730     // Tile row ends here

`endif

//--- verilog/lcd_pkg.sv
`include "lcd_defines.svh"

package lcd_pkg;

	typedef logic [`LCD_FRAME_W-1:0] frame_t;      // MSB-aligned frame bits
	typedef logic [6:0]              frame_len_t;  // Bits in a frame
	typedef logic [3:0]              frame_idx_t;  // Slot in the pass
	typedef logic [`LCD_TOUCH_W-1:0] touch_word_t;
	typedef logic [15:0]             coord_t;
	typedef logic [3:0]              freq_sel_t;   // 0 none, 1..11 tiles

	// Run/off and sweep/lock selections
	typedef enum logic [1:0] {
		MODE_NONE   = 2'd0,
		MODE_FIRST  = 2'd1,
		MODE_SECOND = 2'd2
	} mode_sel_e;

	typedef enum logic [1:0] {
		SH_IDLE  = 2'd0,
		SH_SHIFT = 2'd1,
		SH_GAP   = 2'd2
	} shifter_state_e;

endpackage

//--- verilog/lcd_frame_sequencer.sv
`timescale 1ns/1ps
`include "lcd_defines.svh"

module lcd_frame_sequencer import lcd_pkg::*; (
	input  logic       clk20MHz,
	input  logic       reset,
	input  freq_sel_t  freq_sel,
	input  mode_sel_e  run_sel,
	input  mode_sel_e  sweep_sel,
	input  logic       buf_full,
	output logic       seq_load,
	output frame_t     seq_data,
	output frame_len_t seq_len,
	output logic       seq_capture
);

	frame_idx_t idx;
	frame_idx_t idx_next;
	logic       built;           // Frame regs match idx
	frame_t     nxt_data;
	frame_len_t nxt_len;
	logic       nxt_capture;
	logic [7:0] tile_addr;
	logic [7:0] tile_color;
	logic [7:0] mode_byte;

	assign idx_next = (idx == frame_idx_t'(`LCD_PASS_FRAMES - 1)) ? '0 : idx + 4'd1;
	assign tile_addr = `LCD_TILE_BASE + {4'd0, idx - 4'd1} * `LCD_TILE_STEP;
	assign tile_color = (freq_sel == idx) ? `LCD_COLOR_SEL : `LCD_COLOR_IDLE;
	assign mode_byte = {4'h0, sweep_sel, run_sel};

	// Frame content for the current slot
	always_comb begin
		nxt_data = '0;
		nxt_len = `LCD_LEN_CMD;
		nxt_capture = 1'b0;
		if (idx >= frame_idx_t'(`LCD_PASS_FRAMES - `LCD_POLL_FRAMES)) begin
			nxt_data = `LCD_CMD_TOUCH_RD;
			nxt_len = `LCD_LEN_READ;
			nxt_capture = 1'b1;          // Reply goes to the decoder
		end else if (idx == frame_idx_t'(`LCD_FREQ_TILES + 1)) begin
			nxt_data = {`LCD_MODE_ADDR0, `LCD_MODE_ADDR1, `LCD_MODE_ADDR2,
				mode_byte, 32'h0};
			nxt_len = `LCD_LEN_WRITE;
		end else if (idx != '0) begin
			nxt_data = {`LCD_WR_CMD, `LCD_WR_PAGE, tile_addr, tile_color, 32'h0};
			nxt_len = `LCD_LEN_WRITE;
		end else begin
			nxt_data = {`LCD_CMD_ACTIVE, 40'h0};   // Wake command
		end
	end

	always_ff @(posedge clk20MHz) begin
		if (reset) begin
			idx <= '0;
			built <= 1'b0;
			seq_load <= 1'b0;
		end else begin
			seq_load <= 1'b0;
			if (!built) begin
				built <= 1'b1;
			end else if (!buf_full) begin
				seq_load <= 1'b1;        // Frame regs stay valid this cycle
				built <= 1'b0;
				idx <= idx_next;
			end
		end
	end

	// Selections are sampled here, then held through back-pressure
	always_ff @(posedge clk20MHz) begin
		if (!built) begin
			seq_data <= nxt_data;
			seq_len <= nxt_len;
			seq_capture <= nxt_capture;
		end
	end

	a_idx_range: assert property (@(posedge clk20MHz) disable iff (reset)
		idx <= frame_idx_t'(`LCD_PASS_FRAMES - 1))
		else $error("Frame index %0d past end of pass", idx);

endmodule

//--- verilog/lcd_frame_buffer.sv
`timescale 1ns/1ps

module lcd_frame_buffer import lcd_pkg::*; (
	input  logic       clk20MHz,
	input  logic       reset,
	input  logic       seq_load,
	input  frame_t     seq_data,
	input  frame_len_t seq_len,
	input  logic       seq_capture,
	input  logic       buf_take,
	output logic       buf_full,
	output frame_t     buf_data,
	output frame_len_t buf_len,
	output logic       buf_capture
);

	always_ff @(posedge clk20MHz) begin
		if (reset) begin
			buf_full <= 1'b0;
		end else if (seq_load) begin
			buf_full <= 1'b1;
		end else if (buf_take) begin
			buf_full <= 1'b0;
		end
	end

	always_ff @(posedge clk20MHz) begin
		if (seq_load) begin
			buf_data <= seq_data;
			buf_len <= seq_len;
			buf_capture <= seq_capture;
		end
	end

	// Sequencer must wait for the shifter to drain the entry
	a_load_empty: assert property (@(posedge clk20MHz) disable iff (reset)
		seq_load |-> !buf_full)
		else $error("Load into a full frame buffer");

	a_take_full: assert property (@(posedge clk20MHz) disable iff (reset)
		buf_take |-> buf_full)
		else $error("Take from an empty frame buffer");

endmodule

//--- verilog/lcd_spi_shifter.sv
`timescale 1ns/1ps
`include "lcd_defines.svh"

module lcd_spi_shifter import lcd_pkg::*; (
	input  logic        clk20MHz,
	input  logic        reset,
	input  logic        buf_full,
	input  frame_t      buf_data,
	input  frame_len_t  buf_len,
	input  logic        buf_capture,
	output logic        buf_take,
	input  logic        miso,
	output logic        sclk,
	output logic        mosi,
	output logic        cs_n,
	output logic        rx_valid,
	output touch_word_t rx_word
);

	shifter_state_e state;
	logic [7:0]     tick;           // Half-period or gap count
	frame_len_t     bits_left;
	logic           capture;
	frame_t         tx_shift;
	touch_word_t    rx_shift;
	logic           half_done;
	logic           rise;
	logic           fall;
	logic           last;

	assign buf_take = (state == SH_IDLE) && buf_full;
	assign half_done = (tick == 8'(`LCD_SCLK_HALF - 1));
	assign rise = (state == SH_SHIFT) && half_done && !sclk;
	assign fall = (state == SH_SHIFT) && half_done && sclk;
	assign last = fall && (bits_left == 7'd1);

	always_ff @(posedge clk20MHz) begin
		if (reset) begin
			state <= SH_IDLE;
			tick <= '0;
			bits_left <= '0;
			capture <= 1'b0;
			sclk <= 1'b0;
			mosi <= 1'b0;
			cs_n <= 1'b1;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				SH_IDLE: begin
					if (buf_full) begin
						state <= SH_SHIFT;
						tick <= '0;
						bits_left <= buf_len;
						capture <= buf_capture;
						cs_n <= 1'b0;
						mosi <= buf_data[`LCD_FRAME_W-1];   // MSB first
					end
				end
				SH_SHIFT: begin
					tick <= half_done ? 8'd0 : tick + 8'd1;
					if (rise) begin
						sclk <= 1'b1;
					end else if (last) begin
						sclk <= 1'b0;
						cs_n <= 1'b1;        // Half-period after last rise
						mosi <= 1'b0;
						rx_valid <= capture;
						state <= SH_GAP;
					end else if (fall) begin
						sclk <= 1'b0;
						mosi <= tx_shift[`LCD_FRAME_W-2];
						bits_left <= bits_left - 7'd1;
					end
				end
				SH_GAP: begin
					tick <= tick + 8'd1;
					if (tick == 8'(`LCD_CS_GAP - 1)) begin
						state <= SH_IDLE;
					end
				end
				default: state <= SH_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk20MHz) begin
		if (buf_take) begin
			tx_shift <= buf_data;
		end else if (fall) begin
			tx_shift <= tx_shift << 1;
		end
		if (rise) begin
			rx_shift <= {rx_shift[`LCD_TOUCH_W-2:0], miso};   // Sample on rising sclk
		end
		if (last) begin
			rx_word <= rx_shift;
		end
	end

	// Chip select gap holds for the full count after every frame
	a_cs_gap: assert property (@(posedge clk20MHz) disable iff (reset)
		$rose(cs_n) |-> (cs_n && state == SH_GAP) [*`LCD_CS_GAP])
		else $error("cs_n gap shorter than %0d cycles", `LCD_CS_GAP);

endmodule

//--- verilog/lcd_touch_decoder.sv
`timescale 1ns/1ps
`include "lcd_defines.svh"

module lcd_touch_decoder import lcd_pkg::*; (
	input  logic        clk20MHz,
	input  logic        reset,
	input  logic        rx_valid,
	input  touch_word_t rx_word,
	output logic        run,
	output logic        off,
	output logic        sweep,
	output logic        lock,
	output freq_sel_t   freq_cho,
	output freq_sel_t   freq_sel,
	output mode_sel_e   run_sel,
	output mode_sel_e   sweep_sel
);

	coord_t    x;
	coord_t    y;
	logic      status_ok;
	logic      hit_run;
	logic      hit_off;
	logic      hit_sweep;
	logic      hit_lock;
	freq_sel_t tile_hit;

	function automatic logic in_box(input coord_t px, input coord_t py,
		input coord_t x_lo, input coord_t x_hi, input coord_t y_lo, input coord_t y_hi);
		return (px >= x_lo) && (px <= x_hi) && (py >= y_lo) && (py <= y_hi);
	endfunction

	// Controller sends each coordinate low byte first
	assign x = {rx_word[7:0], rx_word[15:8]};
	assign y = {rx_word[23:16], rx_word[31:24]};
	assign status_ok = (rx_word[39:32] == `LCD_TOUCH_OK);

	assign hit_run = in_box(x, y, `LCD_RUN_X_LO, `LCD_RUN_X_HI, `LCD_RUN_Y_LO, `LCD_RUN_Y_HI);
	assign hit_off = in_box(x, y, `LCD_OFF_X_LO, `LCD_OFF_X_HI, `LCD_OFF_Y_LO, `LCD_OFF_Y_HI);
	assign hit_sweep = in_box(x, y, `LCD_SWEEP_X_LO, `LCD_SWEEP_X_HI,
		`LCD_SWEEP_Y_LO, `LCD_SWEEP_Y_HI);
	assign hit_lock = in_box(x, y, `LCD_LOCK_X_LO, `LCD_LOCK_X_HI,
		`LCD_LOCK_Y_LO, `LCD_LOCK_Y_HI);

	always_comb begin
		tile_hit = '0;
		if (y <= `LCD_TILE_Y_HI) begin
			if (x >= `LCD_T1_X_LO && x <= `LCD_T1_X_HI) tile_hit = 4'd1;
			else if (x >= `LCD_T2_X_LO && x <= `LCD_T2_X_HI) tile_hit = 4'd2;
			else if (x >= `LCD_T3_X_LO && x <= `LCD_T3_X_HI) tile_hit = 4'd3;
			else if (x >= `LCD_T4_X_LO && x <= `LCD_T4_X_HI) tile_hit = 4'd4;
			else if (x >= `LCD_T5_X_LO && x <= `LCD_T5_X_HI) tile_hit = 4'd5;
			else if (x >= `LCD_T6_X_LO && x <= `LCD_T6_X_HI) tile_hit = 4'd6;
			else if (x >= `LCD_T7_X_LO && x <= `LCD_T7_X_HI) tile_hit = 4'd7;
			else if (x >= `LCD_T8_X_LO && x <= `LCD_T8_X_HI) tile_hit = 4'd8;
			else if (x >= `LCD_T9_X_LO && x <= `LCD_T9_X_HI) tile_hit = 4'd9;
			else if (x >= `LCD_T10_X_LO && x <= `LCD_T10_X_HI) tile_hit = 4'd10;
			else if (x >= `LCD_T11_X_LO && x <= `LCD_T11_X_HI) tile_hit = 4'd11;
		end
	end

	always_ff @(posedge clk20MHz) begin
		if (reset) begin
			run <= 1'b0;
			off <= 1'b0;
			sweep <= 1'b0;
			lock <= 1'b0;
			freq_cho <= '0;
			freq_sel <= '0;
			run_sel <= MODE_NONE;
			sweep_sel <= MODE_NONE;
		end else begin
			run <= 1'b0;
			off <= 1'b0;
			sweep <= 1'b0;
			lock <= 1'b0;
			freq_cho <= '0;
			if (rx_valid && status_ok) begin
				if (hit_run) begin           // First match wins
					run <= 1'b1;
					run_sel <= MODE_FIRST;
				end else if (hit_off) begin
					off <= 1'b1;
					run_sel <= MODE_SECOND;
				end else if (hit_sweep) begin
					sweep <= 1'b1;
					sweep_sel <= MODE_FIRST;
				end else if (hit_lock) begin
					lock <= 1'b1;
					sweep_sel <= MODE_SECOND;
				end else if (tile_hit != '0) begin
					freq_cho <= tile_hit;
					freq_sel <= tile_hit;
				end
			end
		end
	end

	a_one_cmd: assert property (@(posedge clk20MHz) disable iff (reset)
		$onehot0({run, off, sweep, lock, freq_cho != '0}))
		else $error("More than one command pulse");

endmodule

//--- verilog/lcd_panel_top.sv
`timescale 1ns/1ps

module lcd_panel_top import lcd_pkg::*; (
	input  logic      clk20MHz,
	input  logic      reset,
	input  logic      miso,
	output logic      sclk,
	output logic      mosi,
	output logic      cs_n,
	output logic      run,
	output logic      off,
	output logic      sweep,
	output logic      lock,
	output freq_sel_t freq_cho
);

	logic        seq_load;
	frame_t      seq_data;
	frame_len_t  seq_len;
	logic        seq_capture;
	logic        buf_full;
	frame_t      buf_data;
	frame_len_t  buf_len;
	logic        buf_capture;
	logic        buf_take;
	logic        rx_valid;
	touch_word_t rx_word;
	freq_sel_t   freq_sel;
	mode_sel_e   run_sel;
	mode_sel_e   sweep_sel;

	lcd_frame_sequencer u_sequencer (
		.clk20MHz    (clk20MHz),
		.reset       (reset),
		.freq_sel    (freq_sel),
		.run_sel     (run_sel),
		.sweep_sel   (sweep_sel),
		.buf_full    (buf_full),
		.seq_load    (seq_load),
		.seq_data    (seq_data),
		.seq_len     (seq_len),
		.seq_capture (seq_capture)
	);

	lcd_frame_buffer u_buffer (
		.clk20MHz    (clk20MHz),
		.reset       (reset),
		.seq_load    (seq_load),
		.seq_data    (seq_data),
		.seq_len     (seq_len),
		.seq_capture (seq_capture),
		.buf_take    (buf_take),
		.buf_full    (buf_full),
		.buf_data    (buf_data),
		.buf_len     (buf_len),
		.buf_capture (buf_capture)
	);

	lcd_spi_shifter u_shifter (
		.clk20MHz    (clk20MHz),
		.reset       (reset),
		.buf_full    (buf_full),
		.buf_data    (buf_data),
		.buf_len     (buf_len),
		.buf_capture (buf_capture),
		.buf_take    (buf_take),
		.miso        (miso),
		.sclk        (sclk),
		.mosi        (mosi),
		.cs_n        (cs_n),
		.rx_valid    (rx_valid),
		.rx_word     (rx_word)
	);

	lcd_touch_decoder u_decoder (
		.clk20MHz    (clk20MHz),
		.reset       (reset),
		.rx_valid    (rx_valid),
		.rx_word     (rx_word),
		.run         (run),
		.off         (off),
		.sweep       (sweep),
		.lock        (lock),
		.freq_cho    (freq_cho),
		.freq_sel    (freq_sel),
		.run_sel     (run_sel),
		.sweep_sel   (sweep_sel)
	);

endmodule

//--- verif/lcd_panel_tb.sv
`timescale 1ns/1ps
`include "lcd_defines.svh"

module lcd_panel_tb import lcd_pkg::*; ();

	typedef enum logic [2:0] {
		PULSE_NONE,
		PULSE_RUN,
		PULSE_OFF,
		PULSE_SWEEP,
		PULSE_LOCK,
		PULSE_FREQ
	} pulse_e;

	// One touch reply and the state expected after it
	typedef struct packed {
		logic [7:0] status;
		coord_t     x;
		coord_t     y;
		pulse_e     pulse;
		freq_sel_t  freq;
		mode_sel_e  run;
		mode_sel_e  sweep;
	} row_t;

	localparam int ROW_COUNT = 14;
	localparam int FRAME_CYCLES = `LCD_FRAME_W * 2 * `LCD_SCLK_HALF + `LCD_CS_GAP + 4;
	localparam int TIMEOUT_CYCLES = ROW_COUNT * 2 * `LCD_PASS_FRAMES * FRAME_CYCLES + 16;

	logic        clk20MHz;
	logic        reset = 1'b1;
	logic        miso = 1'b0;
	logic        sclk;
	logic        mosi;
	logic        cs_n;
	logic        run;
	logic        off;
	logic        sweep;
	logic        lock;
	freq_sel_t   freq_cho;

	row_t        stim [ROW_COUNT];
	int          row_sel;
	int unsigned seed_val;
	int          frame_cnt = 0;
	int          bit_cnt = 0;
	int          gap_cnt = 0;
	int          miso_idx = -1;
	int          rows_done = 0;
	int          errors = 0;
	int          err_mark = 0;
	int          tests = 0;
	int          tests_failed = 0;
	int          run_cnt = 0;
	int          off_cnt = 0;
	int          sweep_cnt = 0;
	int          lock_cnt = 0;
	int          freq_cnt = 0;
	freq_sel_t   freq_val = '0;
	freq_sel_t   exp_freq = '0;
	mode_sel_e   exp_run = MODE_NONE;
	mode_sel_e   exp_sweep = MODE_NONE;
	logic [63:0] mosi_bits = '0;
	logic [63:0] miso_word = '0;
	logic        prev_sclk = 1'b0;
	logic        prev_cs_n = 1'b1;
	logic        idle_checked = 1'b0;
	logic        done = 1'b0;

	lcd_panel_top dut_i (
		.clk20MHz (clk20MHz),
		.reset    (reset),
		.miso     (miso),
		.sclk     (sclk),
		.mosi     (mosi),
		.cs_n     (cs_n),
		.run      (run),
		.off      (off),
		.sweep    (sweep),
		.lock     (lock),
		.freq_cho (freq_cho)
	);

	initial begin
		clk20MHz = 1'b0;
		forever #25 clk20MHz = ~clk20MHz;   // 20 MHz
	end

	function automatic int expected_len(input int slot);
		if (slot == 0) return 24;
		else if (slot <= `LCD_FREQ_TILES + 1) return 32;
		else return 64;
	endfunction

	// Frame content right-aligned, as the device model collects it
	function automatic logic [63:0] expected_frame(input int slot, input freq_sel_t f,
		input mode_sel_e r, input mode_sel_e s);
		logic [7:0] addr;
		logic [7:0] color;
		addr = `LCD_TILE_BASE + 8'(slot - 1) * `LCD_TILE_STEP;
		color = (f == 4'(slot)) ? 8'h00 : 8'hFF;
		if (slot == 0) return 64'(`LCD_CMD_ACTIVE);
		else if (slot <= `LCD_FREQ_TILES) return {32'h0, `LCD_WR_CMD, `LCD_WR_PAGE, addr, color};
		else if (slot == `LCD_FREQ_TILES + 1)
			return {32'h0, `LCD_MODE_ADDR0, `LCD_MODE_ADDR1, `LCD_MODE_ADDR2, 4'h0, s, r};
		else return `LCD_CMD_TOUCH_RD;
	endfunction

	function automatic logic [39:0] touch_reply(input logic [7:0] status, input coord_t x,
		input coord_t y);
		return {status, y[7:0], y[15:8], x[7:0], x[15:8]};   // Low byte first
	endfunction

	task automatic check_hex(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp) else begin
			$display("CHECK FAILED %s: got %0h, expected %0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		tests++;
		if (errors == err_mark) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	task automatic load_table();
		stim[0] = '{8'h42, 16'd150, 16'd800, PULSE_RUN, 4'd0, MODE_FIRST, MODE_NONE};
		stim[1] = '{8'h42, 16'd100, 16'd600, PULSE_OFF, 4'd0, MODE_SECOND, MODE_NONE};
		stim[2] = '{8'h42, 16'd80, 16'd350, PULSE_SWEEP, 4'd0, MODE_SECOND, MODE_FIRST};
		stim[3] = '{8'h42, 16'd200, 16'd100, PULSE_LOCK, 4'd0, MODE_SECOND, MODE_SECOND};
		stim[4] = '{8'h42, 16'd330, 16'd500, PULSE_FREQ, 4'd1, MODE_SECOND, MODE_SECOND};
		stim[5] = '{8'h42, 16'd860, 16'd700, PULSE_FREQ, 4'd10, MODE_SECOND, MODE_SECOND};
		stim[6] = '{8'h41, 16'd150, 16'd800, PULSE_NONE, 4'd10, MODE_SECOND, MODE_SECOND};
		stim[7] = '{8'h42, 16'd250, 16'd500, PULSE_NONE, 4'd10, MODE_SECOND, MODE_SECOND};
		stim[8] = '{8'h42, 16'd630, 16'd760, PULSE_NONE, 4'd10, MODE_SECOND, MODE_SECOND};
		stim[9] = '{8'h42, 16'd84, 16'd768, PULSE_RUN, 4'd10, MODE_FIRST, MODE_SECOND};
		stim[10] = '{8'h42, 16'd940, 16'd730, PULSE_FREQ, 4'd11, MODE_FIRST, MODE_SECOND};
		stim[11] = '{8'h42, 16'd75, 16'd545, PULSE_OFF, 4'd11, MODE_SECOND, MODE_SECOND};
		stim[12] = '{8'h42, 16'd570, 16'd300, PULSE_FREQ, 4'd5, MODE_SECOND, MODE_SECOND};
		stim[13] = '{8'h42, 16'd690, 16'd10, PULSE_FREQ, 4'd7, MODE_SECOND, MODE_SECOND};
	endtask

	task automatic check_row(input int r);
		row_t cur;
		cur = stim[r];
		check_hex("run pulses", 64'(run_cnt), 64'(cur.pulse == PULSE_RUN));
		check_hex("off pulses", 64'(off_cnt), 64'(cur.pulse == PULSE_OFF));
		check_hex("sweep pulses", 64'(sweep_cnt), 64'(cur.pulse == PULSE_SWEEP));
		check_hex("lock pulses", 64'(lock_cnt), 64'(cur.pulse == PULSE_LOCK));
		check_hex("freq_cho cycles", 64'(freq_cnt), 64'(cur.pulse == PULSE_FREQ));
		if (cur.pulse == PULSE_FREQ) check_hex("freq_cho", 64'(freq_val), 64'(cur.freq));
		check_hex("freq_sel", 64'(dut_i.freq_sel), 64'(cur.freq));
		check_hex("run_sel", 64'(dut_i.run_sel), 64'(cur.run));
		check_hex("sweep_sel", 64'(dut_i.sweep_sel), 64'(cur.sweep));
		exp_freq = cur.freq;        // Next pass shows these
		exp_run = cur.run;
		exp_sweep = cur.sweep;
		run_cnt = 0;
		off_cnt = 0;
		sweep_cnt = 0;
		lock_cnt = 0;
		freq_cnt = 0;
		report_test($sformatf("row %0d status %h x %0d y %0d", r, cur.status, cur.x, cur.y));
		rows_done++;
	endtask

	task automatic start_frame();
		int slot;
		logic [39:0] reply;
		if (frame_cnt > 0) begin
			assert (gap_cnt >= `LCD_CS_GAP) else begin
				$display("cs_n was high only %0d cycles before frame %0d", gap_cnt, frame_cnt);
				errors++;
			end
		end
		bit_cnt = 0;
		mosi_bits = '0;
		slot = frame_cnt % `LCD_PASS_FRAMES;
		if (slot >= `LCD_PASS_FRAMES - `LCD_POLL_FRAMES) begin
			if (slot == `LCD_PASS_FRAMES - `LCD_POLL_FRAMES
				&& frame_cnt / `LCD_PASS_FRAMES < ROW_COUNT)
				reply = touch_reply(stim[row_sel].status, stim[row_sel].x, stim[row_sel].y);
			else
				reply = {8'h00, 32'($urandom)};   // Bad status between rows
			miso_word = {24'($urandom), reply};
		end else begin
			miso_word = '0;
		end
		miso <= miso_word[63];
		miso_idx = 62;
	endtask

	task automatic finish_frame();
		int slot;
		int pass_no;
		slot = frame_cnt % `LCD_PASS_FRAMES;
		pass_no = frame_cnt / `LCD_PASS_FRAMES;
		check_hex("mosi bit count", 64'(bit_cnt), 64'(expected_len(slot)));
		check_hex("mosi frame", mosi_bits, expected_frame(slot, exp_freq, exp_run, exp_sweep));
		frame_cnt++;
		gap_cnt = 0;
		if (slot == `LCD_PASS_FRAMES - 1 && pass_no < ROW_COUNT) begin
			check_row(pass_no);
		end else if (pass_no == ROW_COUNT && slot == `LCD_FREQ_TILES + 1) begin
			report_test("final pass frames");
			done = 1'b1;
		end
	endtask

	// SPI device model and monitor, all sampled on the rising clock
	always @(posedge clk20MHz) begin
		if (!reset) begin
			if (!idle_checked) begin
				check_hex("cs_n", 64'(cs_n), 64'h1);
				check_hex("sclk", 64'(sclk), 64'h0);
				check_hex("mosi", 64'(mosi), 64'h0);
				check_hex("pulse outputs", 64'({run, off, sweep, lock, freq_cho}), 64'h0);
				report_test("reset state");
				idle_checked = 1'b1;
			end
			if (run) run_cnt++;
			if (off) off_cnt++;
			if (sweep) sweep_cnt++;
			if (lock) lock_cnt++;
			if (freq_cho != '0) begin
				freq_cnt++;
				freq_val = freq_cho;
			end
			if (!prev_cs_n && cs_n) finish_frame();
			if (cs_n) gap_cnt++;
			if (prev_cs_n && !cs_n) start_frame();
			if (!cs_n && !prev_sclk && sclk) begin
				mosi_bits = {mosi_bits[62:0], mosi};   // Rising sclk
				bit_cnt++;
			end
			if (!cs_n && prev_sclk && !sclk && miso_idx >= 0) begin
				miso <= miso_word[miso_idx];           // Falling sclk
				miso_idx--;
			end
		end
		prev_sclk = sclk;
		prev_cs_n = cs_n;
	end

	initial begin
		seed_val = $urandom(32'h7910);
		load_table();
		row_sel = 0;
		repeat (8) @(posedge clk20MHz);
		reset <= 1'b0;
		for (int r = 0; r < ROW_COUNT; r++) begin
			row_sel = r;
			wait (rows_done == r + 1);
		end
		wait (done);
		$display("tests %0d, tests failing %0d, check errors %0d", tests, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk20MHz);
		$display("Timeout, run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+verilog
verilog/lcd_pkg.sv
verilog/lcd_frame_sequencer.sv
verilog/lcd_frame_buffer.sv
verilog/lcd_spi_shifter.sv
verilog/lcd_touch_decoder.sv
verilog/lcd_panel_top.sv
verif/lcd_panel_tb.sv

//--- Makefile
# Verilator build and run of the touch-panel front end

VERILATOR ?= verilator
TOP       ?= lcd_panel_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= SIMULATION PASSED

SOURCES := $(wildcard verilog/*.sv verilog/*.svh verif/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
